// ==== source/gb_mem_pkg.sv ====
`default_nettype none

package gb_mem_pkg;

	typedef logic [15:0] adr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [12:0] vram_adr_t;
	typedef logic [7:0]  oam_adr_t;
	typedef logic [6:0]  hram_adr_t;

	localparam int    DMA_LEN      = 160;     // oam size and copy length.
	localparam int    VRAM_LEN     = 8192;
	localparam int    HRAM_LEN     = 127;
	localparam byte_t DMA_REG_LO   = 8'h46;
	localparam byte_t OPEN_BUS     = 8'hff;   // blocked or unmapped read.
	localparam byte_t VRAM_PAGE_LO = 8'h80;
	localparam byte_t VRAM_PAGE_HI = 8'h9f;
	localparam byte_t XRAM_PAGE_LO = 8'ha0;
	localparam byte_t WRAM_PAGE_LO = 8'hc0;
	localparam byte_t OAM_PAGE     = 8'hfe;
	localparam byte_t IO_PAGE      = 8'hff;

	typedef struct packed {
		adr_t  adr;
		byte_t wdata;
		logic  rd;
		logic  wr;
	} cpu_req_t;

	typedef struct packed {
		logic  need_vram;
		logic  need_oam;
		logic  rd;
		adr_t  adr;
	} ppu_req_t;

	typedef struct packed {
		logic rom;
		logic vram;
		logic xram;
		logic wram;
		logic oam;
		logic hram;
		logic dma_reg;
	} mem_sel_t;

	typedef struct packed {
		adr_t  adr;
		byte_t wdata;
		logic  rd;
		logic  wr;
		logic  cs_rom;
		logic  cs_xram;
		logic  cs_wram;
	} ext_bus_t;

	typedef enum logic [1:0] {
		IDLE,
		COPY,
		DRAIN
	} dma_state_t;

endpackage

`default_nettype wire

// ==== source/gb_memmap.sv ====
`timescale 1ns/10ps
`default_nettype none

module gb_memmap (
	input  gb_mem_pkg::adr_t     adr,
	input  logic                 enable,
	output gb_mem_pkg::mem_sel_t sel
);

	gb_mem_pkg::byte_t page;
	gb_mem_pkg::byte_t lo;

	assign page = adr[15:8];
	assign lo   = adr[7:0];

	always_comb begin
		sel = '0;
		if (enable) begin
			sel.rom  = page < gb_mem_pkg::VRAM_PAGE_LO;
			sel.vram = page >= gb_mem_pkg::VRAM_PAGE_LO &&
				page <= gb_mem_pkg::VRAM_PAGE_HI;
			sel.xram = page >= gb_mem_pkg::XRAM_PAGE_LO &&
				page < gb_mem_pkg::WRAM_PAGE_LO;
			sel.wram = page >= gb_mem_pkg::WRAM_PAGE_LO &&
				page < gb_mem_pkg::OAM_PAGE;          // echo area included.
			sel.oam  = page == gb_mem_pkg::OAM_PAGE &&
				lo < 8'(gb_mem_pkg::DMA_LEN);
			sel.dma_reg = page == gb_mem_pkg::IO_PAGE &&
				lo == gb_mem_pkg::DMA_REG_LO;
			// ffff is the interrupt enable, not high ram.
			sel.hram = page == gb_mem_pkg::IO_PAGE && lo[7] && lo != 8'hff;
		end

		assert ($onehot0(sel))
			else $error("gb_memmap: more than one region for %h", adr);
	end

endmodule

`default_nettype wire

// ==== source/oam_dma.sv ====
`timescale 1ns/10ps
`default_nettype none

module oam_dma (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  gb_mem_pkg::cpu_req_t cpu,
	input  gb_mem_pkg::mem_sel_t cpu_sel,
	input  gb_mem_pkg::byte_t    src_data,
	output gb_mem_pkg::byte_t    page,
	output gb_mem_pkg::adr_t     src_adr,
	output logic                 src_rd,
	output gb_mem_pkg::oam_adr_t oam_adr,
	output gb_mem_pkg::byte_t    oam_wdata,
	output logic                 oam_wr,
	output logic                 active
);

	gb_mem_pkg::dma_state_t state;
	gb_mem_pkg::oam_adr_t   idx;
	gb_mem_pkg::oam_adr_t   wr_idx;
	logic                   wr_pend;
	logic                   start;

	assign start = cpu.wr && cpu_sel.dma_reg;   // a new write restarts the copy.

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			state   <= gb_mem_pkg::IDLE;
			page    <= '0;
			idx     <= '0;
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= src_rd;
			if (start) begin
				page  <= cpu.wdata;
				idx   <= '0;
				state <= gb_mem_pkg::COPY;
			end else begin
				case (state)
				gb_mem_pkg::COPY: begin
					if (idx == 8'(gb_mem_pkg::DMA_LEN - 1))
						state <= gb_mem_pkg::DRAIN;
					else
						idx <= idx + 8'd1;
				end
				gb_mem_pkg::DRAIN:
					state <= gb_mem_pkg::IDLE;   // last byte lands here.
				default: ;
				endcase
			end
		end
	end

	always_ff @(posedge gbclk) begin
		wr_idx <= idx;
	end

	assign src_rd    = state == gb_mem_pkg::COPY;
	assign src_adr   = {page, idx};
	assign oam_adr   = wr_idx;
	assign oam_wdata = src_data;   // source data arrives one cycle after the read.
	assign oam_wr    = wr_pend;
	assign active    = state != gb_mem_pkg::IDLE;

	a_no_wr_idle: assert property (@(posedge gbclk) disable iff (!rst_n)
		state == gb_mem_pkg::IDLE |-> !oam_wr)
		else $error("oam_dma: oam write while idle");

endmodule

`default_nettype wire

// ==== source/video_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module video_mem (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  gb_mem_pkg::ppu_req_t ppu,
	input  gb_mem_pkg::cpu_req_t cpu,
	input  gb_mem_pkg::mem_sel_t cpu_sel,
	input  logic                 dma_active,
	input  logic                 dma_src_vram,
	input  gb_mem_pkg::adr_t     dma_adr,
	input  logic                 dma_rd,
	input  gb_mem_pkg::oam_adr_t dma_oam_adr,
	input  gb_mem_pkg::byte_t    dma_oam_wdata,
	input  logic                 dma_oam_wr,
	output gb_mem_pkg::byte_t    vram_rdata,
	output gb_mem_pkg::byte_t    oam_rdata,
	output gb_mem_pkg::byte_t    ppu_rdata,
	output logic                 cpu_vram_ok,
	output logic                 cpu_oam_ok
);

	gb_mem_pkg::byte_t    vram [gb_mem_pkg::VRAM_LEN];
	gb_mem_pkg::byte_t    oam  [gb_mem_pkg::DMA_LEN];
	gb_mem_pkg::vram_adr_t vram_adr;
	gb_mem_pkg::oam_adr_t  oam_adr;
	gb_mem_pkg::byte_t    oam_wdata;
	gb_mem_pkg::byte_t    vram_q;
	gb_mem_pkg::byte_t    oam_q;
	logic                 vram_rd;
	logic                 vram_wr;
	logic                 oam_rd;
	logic                 oam_wr;
	logic                 ppu_vram_q;
	logic                 ppu_oam_q;

	always_comb begin
		vram_adr    = cpu.adr[12:0];
		vram_rd     = 1'b0;
		vram_wr     = 1'b0;
		cpu_vram_ok = 1'b0;
		if (ppu.need_vram) begin
			vram_adr = ppu.adr[12:0];
			vram_rd  = ppu.rd;
		end else if (dma_rd && dma_src_vram) begin
			vram_adr = dma_adr[12:0];
			vram_rd  = 1'b1;
		end else if (cpu_sel.vram) begin
			vram_rd     = cpu.rd;
			vram_wr     = cpu.wr;
			cpu_vram_ok = 1'b1;
		end
	end

	always_comb begin
		oam_adr    = cpu.adr[7:0];
		oam_wdata  = cpu.wdata;
		oam_rd     = 1'b0;
		oam_wr     = 1'b0;
		cpu_oam_ok = 1'b0;
		if (ppu.need_oam) begin
			oam_adr = ppu.adr[7:0];
			oam_rd  = ppu.rd;
		end else if (dma_active) begin   // oam is locked for the whole transfer.
			oam_adr   = dma_oam_adr;
			oam_wdata = dma_oam_wdata;
			oam_wr    = dma_oam_wr;
		end else if (cpu_sel.oam) begin
			oam_rd     = cpu.rd;
			oam_wr     = cpu.wr;
			cpu_oam_ok = 1'b1;
		end
	end

	always_ff @(posedge gbclk) begin
		if (vram_wr)
			vram[vram_adr] <= cpu.wdata;
		if (vram_rd)
			vram_q <= vram[vram_adr];
		if (oam_wr)
			oam[oam_adr] <= oam_wdata;
		if (oam_rd)
			oam_q <= oam_adr < 8'(gb_mem_pkg::DMA_LEN) ? oam[oam_adr] : gb_mem_pkg::OPEN_BUS;
	end

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			ppu_vram_q <= 1'b0;
			ppu_oam_q  <= 1'b0;
		end else begin
			ppu_vram_q <= ppu.need_vram;
			ppu_oam_q  <= ppu.need_oam;
		end
	end

	// dma sees open bus while the ppu held vram.
	assign vram_rdata = ppu_vram_q ? gb_mem_pkg::OPEN_BUS : vram_q;
	assign oam_rdata  = oam_q;
	assign ppu_rdata  = ppu_oam_q ? oam_q : vram_q;

	a_oam_one_writer: assert property (@(posedge gbclk) disable iff (!rst_n)
		$onehot0({dma_oam_wr, cpu.wr && cpu_oam_ok}))
		else $error("video_mem: dma and cpu write oam together");

endmodule

`default_nettype wire

// ==== source/cpu_data_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_data_path (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  gb_mem_pkg::cpu_req_t cpu,
	input  gb_mem_pkg::mem_sel_t cpu_sel,
	input  logic                 dma_active,
	input  gb_mem_pkg::mem_sel_t dma_sel,
	input  gb_mem_pkg::adr_t     dma_adr,
	input  logic                 dma_rd,
	input  gb_mem_pkg::byte_t    dma_page,
	input  logic                 cpu_vram_ok,
	input  logic                 cpu_oam_ok,
	input  gb_mem_pkg::byte_t    vram_rdata,
	input  gb_mem_pkg::byte_t    oam_rdata,
	input  gb_mem_pkg::byte_t    ext_rdata,
	output gb_mem_pkg::ext_bus_t ext,
	output gb_mem_pkg::byte_t    dma_src_data,
	output gb_mem_pkg::byte_t    cpu_rdata,
	output logic                 cpu_rvalid
);

	gb_mem_pkg::byte_t     hram [gb_mem_pkg::HRAM_LEN];
	gb_mem_pkg::hram_adr_t hram_adr;
	gb_mem_pkg::byte_t     hram_q;
	gb_mem_pkg::byte_t     ext_q;
	gb_mem_pkg::mem_sel_t  cpu_won;
	gb_mem_pkg::mem_sel_t  won_q;
	logic                  dma_ext;
	logic                  cpu_ext;
	logic                  dma_vram_q;
	logic                  dma_ext_q;
	logic                  rvalid_q;

	assign hram_adr = cpu.adr[6:0];
	assign cpu_ext  = cpu_sel.rom || cpu_sel.xram || cpu_sel.wram;
	assign dma_ext  = dma_active && dma_rd && (dma_sel.rom || dma_sel.xram || dma_sel.wram);

	always_comb begin
		ext.wdata = cpu.wdata;
		if (dma_ext) begin   // dma owns the bus, cpu access is dropped.
			ext.adr     = dma_adr;
			ext.rd      = dma_rd;
			ext.wr      = 1'b0;
			ext.cs_rom  = dma_sel.rom;
			ext.cs_xram = dma_sel.xram;
			ext.cs_wram = dma_sel.wram;
		end else begin
			ext.adr     = cpu.adr;
			ext.rd      = cpu.rd && cpu_ext;
			ext.wr      = cpu.wr && cpu_ext;
			ext.cs_rom  = cpu_sel.rom;
			ext.cs_xram = cpu_sel.xram;
			ext.cs_wram = cpu_sel.wram;
		end
	end

	always_comb begin
		cpu_won      = cpu_sel;
		cpu_won.vram = cpu_vram_ok;
		cpu_won.oam  = cpu_oam_ok;
		cpu_won.rom  = cpu_sel.rom && !dma_ext;
		cpu_won.xram = cpu_sel.xram && !dma_ext;
		cpu_won.wram = cpu_sel.wram && !dma_ext;
	end

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			rvalid_q   <= 1'b0;
			won_q      <= '0;
			dma_vram_q <= 1'b0;
			dma_ext_q  <= 1'b0;
		end else begin
			rvalid_q   <= cpu.rd;
			won_q      <= cpu.rd ? cpu_won : '0;
			dma_vram_q <= dma_rd && dma_sel.vram;
			dma_ext_q  <= dma_ext;
		end
	end

	always_ff @(posedge gbclk) begin
		ext_q <= ext_rdata;   // async sram data, sampled at the end of the cycle.
		if (cpu.wr && cpu_sel.hram)
			hram[hram_adr] <= cpu.wdata;
		if (cpu.rd && cpu_sel.hram)
			hram_q <= hram[hram_adr];
	end

	always_comb begin
		cpu_rdata = gb_mem_pkg::OPEN_BUS;
		if (won_q.vram)
			cpu_rdata = vram_rdata;
		else if (won_q.oam)
			cpu_rdata = oam_rdata;
		else if (won_q.rom || won_q.xram || won_q.wram)
			cpu_rdata = ext_q;
		else if (won_q.hram)
			cpu_rdata = hram_q;
		else if (won_q.dma_reg)
			cpu_rdata = dma_page;
	end

	assign cpu_rvalid   = rvalid_q;
	assign dma_src_data = dma_vram_q ? vram_rdata : (dma_ext_q ? ext_q : gb_mem_pkg::OPEN_BUS);

endmodule

`default_nettype wire

// ==== source/gb_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module gb_mem_top (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  gb_mem_pkg::cpu_req_t cpu,
	input  gb_mem_pkg::ppu_req_t ppu,
	input  gb_mem_pkg::byte_t    ext_rdata,
	output gb_mem_pkg::ext_bus_t ext,
	output gb_mem_pkg::byte_t    cpu_rdata,
	output logic                 cpu_rvalid,
	output gb_mem_pkg::byte_t    ppu_rdata,
	output logic                 dma_active
);

	gb_mem_pkg::mem_sel_t cpu_sel;
	gb_mem_pkg::mem_sel_t dma_sel;
	gb_mem_pkg::byte_t    dma_page;
	gb_mem_pkg::adr_t     dma_src_adr;
	logic                 dma_rd;
	gb_mem_pkg::oam_adr_t dma_oam_adr;
	gb_mem_pkg::byte_t    dma_oam_wdata;
	logic                 dma_oam_wr;
	gb_mem_pkg::byte_t    dma_src_data;
	gb_mem_pkg::byte_t    vram_rdata;
	gb_mem_pkg::byte_t    oam_rdata;
	logic                 cpu_vram_ok;
	logic                 cpu_oam_ok;

	gb_memmap cpu_map_i (
		.adr    (cpu.adr),
		.enable (1'b1),
		.sel    (cpu_sel)
	);

	gb_memmap dma_map_i (
		.adr    (dma_src_adr),
		.enable (dma_active),   // no dma selects while idle.
		.sel    (dma_sel)
	);

	oam_dma oam_dma_i (
		.gbclk     (gbclk),
		.rst_n     (rst_n),
		.cpu       (cpu),
		.cpu_sel   (cpu_sel),
		.src_data  (dma_src_data),
		.page      (dma_page),
		.src_adr   (dma_src_adr),
		.src_rd    (dma_rd),
		.oam_adr   (dma_oam_adr),
		.oam_wdata (dma_oam_wdata),
		.oam_wr    (dma_oam_wr),
		.active    (dma_active)
	);

	video_mem video_mem_i (
		.gbclk         (gbclk),
		.rst_n         (rst_n),
		.ppu           (ppu),
		.cpu           (cpu),
		.cpu_sel       (cpu_sel),
		.dma_active    (dma_active),
		.dma_src_vram  (dma_sel.vram),
		.dma_adr       (dma_src_adr),
		.dma_rd        (dma_rd),
		.dma_oam_adr   (dma_oam_adr),
		.dma_oam_wdata (dma_oam_wdata),
		.dma_oam_wr    (dma_oam_wr),
		.vram_rdata    (vram_rdata),
		.oam_rdata     (oam_rdata),
		.ppu_rdata     (ppu_rdata),
		.cpu_vram_ok   (cpu_vram_ok),
		.cpu_oam_ok    (cpu_oam_ok)
	);

	cpu_data_path cpu_data_path_i (
		.gbclk        (gbclk),
		.rst_n        (rst_n),
		.cpu          (cpu),
		.cpu_sel      (cpu_sel),
		.dma_active   (dma_active),
		.dma_sel      (dma_sel),
		.dma_adr      (dma_src_adr),
		.dma_rd       (dma_rd),
		.dma_page     (dma_page),
		.cpu_vram_ok  (cpu_vram_ok),
		.cpu_oam_ok   (cpu_oam_ok),
		.vram_rdata   (vram_rdata),
		.oam_rdata    (oam_rdata),
		.ext_rdata    (ext_rdata),
		.ext          (ext),
		.dma_src_data (dma_src_data),
		.cpu_rdata    (cpu_rdata),
		.cpu_rvalid   (cpu_rvalid)
	);

endmodule

`default_nettype wire

// ==== dv/gb_mem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module gb_mem_tb;

	localparam int RVALID_WAIT = 8;
	localparam int DMA_WAIT    = 400;

	logic                 gbclk;
	logic                 rst_n;
	gb_mem_pkg::cpu_req_t cpu;
	gb_mem_pkg::ppu_req_t ppu;
	gb_mem_pkg::byte_t    ext_rdata;
	gb_mem_pkg::ext_bus_t ext;
	gb_mem_pkg::byte_t    cpu_rdata;
	logic                 cpu_rvalid;
	gb_mem_pkg::byte_t    ppu_rdata;
	logic                 dma_active;

	int errors    = 0;
	int checks    = 0;
	int cycle_cnt = 0;
	bit timed_out = 1'b0;

	gb_mem_top dut_i (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.cpu        (cpu),
		.ppu        (ppu),
		.ext_rdata  (ext_rdata),
		.ext        (ext),
		.cpu_rdata  (cpu_rdata),
		.cpu_rvalid (cpu_rvalid),
		.ppu_rdata  (ppu_rdata),
		.dma_active (dma_active)
	);

	assign ext_rdata = ext.adr[7:0] ^ ext.adr[15:8];   // external memory model.

	initial begin
		gbclk = 1'b0;
		forever #50 gbclk = ~gbclk;
	end

	always @(posedge gbclk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("Error: %s is %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	// expected {cs_rom, cs_xram, cs_wram} for a cpu address.
	function automatic logic [2:0] ext_selects(input gb_mem_pkg::adr_t adr);
		logic [7:0] page;
		page = adr[15:8];
		if (page < 8'h80)
			return 3'b100;
		if (page >= 8'ha0 && page < 8'hc0)
			return 3'b010;
		if (page >= 8'hc0 && page < 8'hfe)
			return 3'b001;
		return 3'b000;
	endfunction

	function automatic logic [7:0] fill_byte(input gb_mem_pkg::adr_t adr, input logic [7:0] seed);
		return (adr[7:0] * 8'd3) ^ adr[15:8] ^ seed;
	endfunction

	function automatic logic [7:0] dma_expect(input logic [7:0] page, input logic [7:0] idx,
		input logic [7:0] seed);
		if (page >= 8'hfe)
			return 8'hff;
		if (page >= 8'h80 && page <= 8'h9f)
			return fill_byte({page, idx}, seed);
		return page ^ idx;   // external source.
	endfunction

	task automatic cpu_write(input gb_mem_pkg::adr_t adr, input gb_mem_pkg::byte_t data);
		logic [2:0] cs;
		cs = ext_selects(adr);
		@(posedge gbclk);
		#10;
		cpu.adr   = adr;
		cpu.wdata = data;
		cpu.wr    = 1'b1;
		@(negedge gbclk);
		check_value($sformatf("ext.wr at %h", adr), 16'(ext.wr), 16'(|cs));
		check_value($sformatf("ext chip selects at %h", adr),
			16'({ext.cs_rom, ext.cs_xram, ext.cs_wram}), 16'(cs));
		if (|cs) begin
			check_value($sformatf("ext.adr at %h", adr), ext.adr, adr);
			check_value($sformatf("ext.wdata at %h", adr), 16'(ext.wdata), 16'(data));
		end
		@(posedge gbclk);
		#10;
		cpu.wr = 1'b0;
	endtask

	task automatic cpu_read(input gb_mem_pkg::adr_t adr, input gb_mem_pkg::byte_t expected);
		int lat;
		@(posedge gbclk);
		#10;
		cpu.adr = adr;
		cpu.rd  = 1'b1;
		@(negedge gbclk);
		check_value("cpu_rvalid in the strobe cycle", 16'(cpu_rvalid), 16'd0);
		@(posedge gbclk);
		#10;
		cpu.rd = 1'b0;
		lat = 1;
		@(negedge gbclk);
		while (!cpu_rvalid && lat < RVALID_WAIT) begin
			@(negedge gbclk);
			lat++;
		end
		if (!cpu_rvalid) begin
			$display("timeout: cpu_rvalid never rose after a read of %h", adr);
			errors++;
			timed_out = 1'b1;
		end else begin
			check_value("cpu_rvalid latency", 16'(lat), 16'd1);
			check_value($sformatf("cpu_rdata at %h", adr), 16'(cpu_rdata), 16'(expected));
			@(negedge gbclk);
			check_value("cpu_rvalid width", 16'(cpu_rvalid), 16'd0);
		end
	endtask

	task automatic set_ppu_need(input logic [1:0] flags);
		@(posedge gbclk);
		#10;
		ppu.need_vram = flags[1];
		ppu.need_oam  = flags[0];
	endtask

	task automatic ppu_read(input gb_mem_pkg::adr_t adr, input gb_mem_pkg::byte_t expected);
		@(posedge gbclk);
		#10;
		ppu.adr = adr;
		ppu.rd  = 1'b1;
		@(posedge gbclk);
		#10;
		ppu.rd = 1'b0;
		@(negedge gbclk);   // data is due one cycle after the strobe.
		check_value($sformatf("ppu_rdata at %h", adr), 16'(ppu_rdata), 16'(expected));
	endtask

	task automatic run_dma(input logic [7:0] page, input logic [7:0] seed);
		int start_cnt;
		int waited;
		if (page >= 8'h80 && page <= 8'h9f) begin
			for (int i = 0; i < 160; i++)
				cpu_write({page, 8'(i)}, fill_byte({page, 8'(i)}, seed));
		end
		@(posedge gbclk);
		#10;
		start_cnt = cycle_cnt;
		cpu.adr   = 16'hff46;
		cpu.wdata = page;
		cpu.wr    = 1'b1;
		@(posedge gbclk);
		#10;
		cpu.wr = 1'b0;
		@(negedge gbclk);
		check_value("dma_active at start", 16'(dma_active), 16'd1);
		if (ext_selects({page, 8'h00}) != 3'b000) begin
			check_value("ext.adr during dma", ext.adr, {page, 8'h00});
			check_value("ext rd and wr during dma", 16'({ext.rd, ext.wr}), 16'b10);
		end
		cpu_read(16'hfe05, 8'hff);   // oam is locked during the copy.
		waited = 0;
		while (dma_active && waited < DMA_WAIT) begin
			@(negedge gbclk);
			waited++;
		end
		if (dma_active) begin
			$display("timeout: dma_active stayed high after a copy from page %h", page);
			errors++;
			timed_out = 1'b1;
		end else begin
			check_value("dma_active cycles", 16'(cycle_cnt - start_cnt - 1), 16'd161);
			for (int i = 0; i < 160 && !timed_out; i++)
				cpu_read(16'hfe00 + 16'(i), dma_expect(page, 8'(i), seed));
			cpu_read(16'hff46, page);
		end
	endtask

	task automatic run_line(input logic [7:0] op, input logic [15:0] arg_a,
		input logic [15:0] arg_b);
		case (op)
		"W": cpu_write(arg_a, arg_b[7:0]);
		"R": cpu_read(arg_a, arg_b[7:0]);
		"P": set_ppu_need(arg_a[1:0]);
		"X": ppu_read(arg_a, arg_b[7:0]);
		"D": run_dma(arg_a[7:0], arg_b[7:0]);
		default: begin
			$display("the test file holds an unknown opcode %c", op);
			errors++;
		end
		endcase
	endtask

	initial begin
		string      line;
		int         fd;
		int         n;
		logic [7:0] op;
		logic [15:0] arg_a;
		logic [15:0] arg_b;
		rst_n = 1'b0;
		cpu   = '0;
		ppu   = '0;
		repeat (10) @(posedge gbclk);
		#10;
		rst_n = 1'b1;
		@(negedge gbclk);
		check_value("cpu_rvalid after reset", 16'(cpu_rvalid), 16'd0);
		check_value("dma_active after reset", 16'(dma_active), 16'd0);
		check_value("ext rd and wr after reset", 16'({ext.rd, ext.wr}), 16'd0);
		fd = $fopen("dv/gb_mem_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test file dv/gb_mem_tests.txt");
			errors++;
		end else begin
			while (!timed_out && $fgets(line, fd) > 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %h %h", op, arg_a, arg_b);
					if (n == 3) begin
						run_line(op, arg_a, arg_b);
					end else begin
						$display("the test file holds a line that cannot be parsed: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0 && checks > 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== gb_mem.f ====
source/gb_mem_pkg.sv
source/gb_memmap.sv
source/oam_dma.sv
source/video_mem.sv
source/cpu_data_path.sv
source/gb_mem_top.sv
dv/gb_mem_tb.sv

// ==== Makefile ====
SIM_LOG = sim.log

all: run

build:
	verilator --binary --timing -j 0 -f gb_mem.f --top-module gb_mem_tb -o gb_mem_sim

run: build
	./obj_dir/gb_mem_sim | tee $(SIM_LOG)
	grep -q "STATUS: PASS" $(SIM_LOG)

lint:
	verilator --lint-only --timing -Wall -f gb_mem.f --top-module gb_mem_top

clean:
	rm -rf obj_dir $(SIM_LOG)

.PHONY: all build run lint clean

// ==== dv/gb_mem_tests.txt ====
# columns: opcode, address or flag value, data or expected value, all hex.
# W write, R read and expect, P ppu need flags (2 vram, 1 oam), X ppu read, D dma page and seed.
R ff46 00
W 8000 12
R 8000 12
W 9fff c3
R 9fff c3
W fe00 a1
R fe00 a1
W fe9f 5e
R fe9f 5e
W ff80 77
R ff80 77
W fffe 88
R fffe 88
R 1234 26
W a5c3 00
R a5c3 66
W c100 99
R c0de 1e
R ff10 ff
R fea0 ff
W 8010 a5
P 2 0
R 8010 ff
W 8010 33
X 8010 a5
P 0 0
R 8010 a5
W fe10 5c
P 1 0
R fe10 ff
W fe10 77
X fe10 5c
P 0 0
R fe10 5c
D c1 00
D 80 5a
D fe 00
